// ==== all.f ====
src/cnn_pkg.sv
src/cnn_ctrl.sv
src/tile_cache.sv
src/conv_pe.sv
src/max_pool.sv
src/cnn_top.sv
test/tb_cnn_assertions.sv
test/tb_cnn.sv

// ==== Bender.yml ====
package:
  name: cnn_conv

sources:
  - files:
      - src/cnn_pkg.sv
      - src/cnn_ctrl.sv
      - src/tile_cache.sv
      - src/conv_pe.sv
      - src/max_pool.sv
      - src/cnn_top.sv
  - target: test
    files:
      - test/tb_cnn_assertions.sv
      - test/tb_cnn.sv

// ==== test/tb_cnn.sv ====
module tb_cnn;

  localparam int period       = 20;
  localparam int reset_cycles = 16;
  localparam int idle_cycles  = 50;
  localparam int run_limit    = 100;  // cycles allowed per run
  localparam int n_runs       = 6;
  localparam int timeout_cycles = n_runs * run_limit + idle_cycles + 2 * reset_cycles;

  typedef logic [cnn_pkg::out_words-1:0][cnn_pkg::data_w-1:0] result_t;

  logic                clk;
  logic                rst;
  logic                start;
  logic                done;
  cnn_pkg::bram_req_t  if_req;
  cnn_pkg::bram_req_t  w_req;
  cnn_pkg::bram_req_t  temp_req;
  cnn_pkg::bram_word_u if_dout;
  cnn_pkg::bram_word_u w_dout;

  logic signed [7:0] pix [cnn_pkg::tile_rows * cnn_pkg::tile_cols];
  logic signed [7:0] wts [cnn_pkg::n_filt * cnn_pkg::k_taps];
  logic [31:0] w_mem [cnn_pkg::w_words];
  logic [31:0] if_mem [cnn_pkg::if_words];
  logic [31:0] temp_mem [cnn_pkg::out_words];
  result_t     exp_q;
  int w_reads;
  int if_reads;
  int wr_cnt;
  int done_cnt;
  logic [31:0] w_first;
  logic [31:0] if_first;
  int err_cnt = 0;
  int check_cnt = 0;
  int errs_before;

  cnn_top UUT (
    .clk        (clk),
    .rst        (rst),
    .i_start    (start),
    .o_done     (done),
    .o_if_req   (if_req),
    .o_w_req    (w_req),
    .o_temp_req (temp_req),
    .i_if_dout  (if_dout),
    .i_w_dout   (w_dout)
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    check_cnt++;
    assert (cond === 1'b1) else begin
      $display("error at %0t: %s", $time, what);
      err_cnt++;
    end
  endtask

  function automatic int total_errors();
    return err_cnt + UUT.u_assertions.err_cnt;
  endfunction

  // conv and relu then rounding to bits 14:7 and a 2x2 max per filter
  function automatic result_t expected_words();
    result_t    words;
    logic [7:0] best;
    logic [7:0] q;
    int         sum;
    words = '0;
    for (int g = 0; g < 2; g++) begin
      for (int f = 0; f < cnn_pkg::n_filt; f++) begin
        best = 8'd0;
        for (int r = 0; r < 2; r++) begin
          for (int c = 2 * g; c < 2 * g + 2; c++) begin
            sum = 0;
            for (int i = 0; i < 5; i++) begin
              for (int j = 0; j < 5; j++) begin
                sum += int'(pix[8 * (r + i) + c + j]) * int'(wts[25 * f + 5 * i + j]);
              end
            end
            if (sum < 0) sum = 0;
            q = 8'((sum >> 7) + ((sum >> 6) & 1)); // wraps past 255
            if (q > best) best = q;
          end
        end
        words[2 * g + f / 4][31 - 8 * (f % 4) -: 8] = best;
      end
    end
    return words;
  endfunction

  // weight and tile brams with one cycle read latency
  always @(posedge clk) begin
    if (w_req.en && w_req.we == 4'b0000) begin
      w_dout.word <= w_mem[w_req.addr];
      if (w_reads == 0) w_first = w_req.addr;
      w_reads++;
    end
    if (if_req.en && if_req.we == 4'b0000) begin
      if_dout.word <= if_mem[if_req.addr];
      if (if_reads == 0) if_first = if_req.addr;
      if_reads++;
    end
    if (done) done_cnt++;
  end

  // temp bram writes checked as they happen
  always @(posedge clk) begin
    if (!rst && temp_req.en && temp_req.we == 4'b1111) begin
      temp_mem[temp_req.addr[1:0]] = temp_req.din;
      expect_eq("temp address", temp_req.addr, 32'(wr_cnt));
      expect_eq("temp word", temp_req.din, exp_q[temp_req.addr[1:0]]);
      wr_cnt++;
    end
  end

  task automatic fill_brams();
    for (int a = 0; a < cnn_pkg::w_words; a++) begin
      w_mem[a] = {wts[4 * a], wts[4 * a + 1], wts[4 * a + 2], wts[4 * a + 3]}; // byte 0 on top
    end
    for (int a = 0; a < cnn_pkg::if_words; a++) begin
      if_mem[a] = {pix[4 * a], pix[4 * a + 1], pix[4 * a + 2], pix[4 * a + 3]};
    end
    for (int a = 0; a < cnn_pkg::out_words; a++) begin
      temp_mem[a] = ~32'(a);
    end
  endtask

  task automatic random_data();
    foreach (pix[i]) pix[i] = 8'($urandom);
    foreach (wts[i]) wts[i] = 8'($urandom);
  endtask

  // one start then wait for done and check the counts
  task automatic run_conv(input bit extra_starts);
    int n;
    fill_brams();
    exp_q = expected_words();
    w_reads = 0;
    if_reads = 0;
    wr_cnt = 0;
    done_cnt = 0;
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    n = 0;
    while (!done && n < run_limit) begin
      @(posedge clk);
      n++;
      start <= extra_starts && (n == 10 || n == 55); // ignored while busy
    end
    expect_true(done, "no done within the cycle limit");
    repeat (4) @(posedge clk);
    expect_eq("temp write count", 32'(wr_cnt), 32'(cnn_pkg::out_words));
    expect_eq("done count", 32'(done_cnt), 32'd1);
    expect_eq("weight reads", 32'(w_reads), 32'(cnn_pkg::w_words));
    expect_eq("tile reads", 32'(if_reads), 32'(cnn_pkg::if_words));
    expect_eq("first weight address", w_first, 32'd0);
    expect_eq("first tile address", if_first, 32'd0);
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s: %s", num, name, (total_errors() == errs_before) ? "ok" : "errors");
    errs_before = total_errors();
  endtask

  initial begin
    rst = 1'b1;
    start = 1'b0;
    if_dout = '0;
    w_dout = '0;
    void'($urandom(30));
    errs_before = 0;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    random_data();
    run_conv(1'b0);
    end_test(1, "random data");

    // all weights -1 so every sum is negative
    foreach (pix[i]) pix[i] = 8'($urandom_range(127, 1));
    foreach (wts[i]) wts[i] = -8'sd1;
    run_conv(1'b0);
    for (int a = 0; a < cnn_pkg::out_words; a++) begin
      expect_eq("relu word", temp_mem[a], 32'd0);
    end
    end_test(2, "negative sums");

    // flat tile of 31 where filter 0 sums to 0x7fff
    foreach (pix[i]) pix[i] = 8'sd31;
    foreach (wts[i]) wts[i] = 8'sd0;
    for (int t = 0; t < 8; t++) wts[t] = 8'sd127;
    wts[8] = 8'sd41;
    for (int f = 1; f < cnn_pkg::n_filt; f++) wts[25 * f] = 8'(3 + 8 * f);
    run_conv(1'b0);
    expect_eq("wrapped byte", 32'(temp_mem[0][31:24]), 32'h00);
    expect_eq("rounded byte", 32'(temp_mem[0][23:16]), 32'h03); // 341 rounds up
    end_test(3, "rounding");

    random_data();
    run_conv(1'b0);
    random_data();
    run_conv(1'b0);
    end_test(4, "back to back");

    rst <= 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
    repeat (idle_cycles) begin
      @(posedge clk);
      expect_true(!(w_req.en || if_req.en || temp_req.en || done ||
                    (|w_req.we) || (|if_req.we) || (|temp_req.we)),
                  "bram enable, write enable or done active with no start");
    end
    random_data();
    run_conv(1'b1);
    end_test(5, "idle and start while busy");

    $display("%0d checks, %0d errors", check_cnt, total_errors());
    if (total_errors() == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #(timeout_cycles * period);
    $display("timeout: the tests did not finish in %0d cycles", timeout_cycles);
    $display("sim failed");
    $finish;
  end

endmodule

// ==== test/tb_cnn_assertions.sv ====
module tb_cnn_assertions (
  input logic               clk,
  input logic               rst,
  input logic               i_done,
  input cnn_pkg::bram_req_t i_if_req,
  input cnn_pkg::bram_req_t i_w_req,
  input cnn_pkg::bram_req_t i_temp_req
);

  int err_cnt = 0;

  done_one_cycle: assert property (@(posedge clk) disable iff (rst) i_done |=> !i_done)
    else begin
      $error("o_done high for two cycles in a row");
      err_cnt++;
    end

  temp_we_needs_en: assert property (@(posedge clk) disable iff (rst)
    (|i_temp_req.we) |-> i_temp_req.en)
    else begin
      $error("temp write enable without bram enable");
      err_cnt++;
    end

  temp_addr_range: assert property (@(posedge clk) disable iff (rst)
    i_temp_req.en |-> (i_temp_req.addr < cnn_pkg::out_words))
    else begin
      $error("temp address out of range");
      err_cnt++;
    end

  // no loads in the done cycle or the one after
  reads_stop_at_done: assert property (@(posedge clk) disable iff (rst)
    i_done |-> !(i_w_req.en || i_if_req.en) ##1 !(i_w_req.en || i_if_req.en))
    else begin
      $error("bram reads while the run is done");
      err_cnt++;
    end

endmodule

bind cnn_top tb_cnn_assertions u_assertions (
  .clk        (clk),
  .rst        (rst),
  .i_done     (o_done),
  .i_if_req   (o_if_req),
  .i_w_req    (o_w_req),
  .i_temp_req (o_temp_req)
);

// ==== src/cnn_top.sv ====
module cnn_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_start,
  output logic                o_done,
  output cnn_pkg::bram_req_t  o_if_req,
  output cnn_pkg::bram_req_t  o_w_req,
  output cnn_pkg::bram_req_t  o_temp_req,
  input  cnn_pkg::bram_word_u i_if_dout,
  input  cnn_pkg::bram_word_u i_w_dout
);

  logic                       load_if;
  logic                       load_w;
  logic [5:0]                 load_idx;
  logic                       sel_valid;   // window request from the fsm
  logic                       sel_row;
  logic [1:0]                 sel_col;
  cnn_pkg::window_t           win;
  logic                       win_valid;
  cnn_pkg::window_t           kernel [cnn_pkg::n_filt];
  logic [cnn_pkg::px_w-1:0]   res [cnn_pkg::n_filt];
  logic [cnn_pkg::n_filt-1:0] res_valid;
  logic                       pool_last;

  cnn_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .i_start     (i_start),
    .i_pool_last (pool_last),
    .o_if_req    (o_if_req),
    .o_w_req     (o_w_req),
    .o_load_if   (load_if),
    .o_load_w    (load_w),
    .o_load_idx  (load_idx),
    .o_win_valid (sel_valid),
    .o_win_row   (sel_row),
    .o_win_col   (sel_col),
    .o_done      (o_done)
  );

  tile_cache u_cache (
    .clk         (clk),
    .rst         (rst),
    .i_if_dout   (i_if_dout),
    .i_w_dout    (i_w_dout),
    .i_load_if   (load_if),
    .i_load_w    (load_w),
    .i_load_idx  (load_idx),
    .i_win_valid (sel_valid),
    .i_win_row   (sel_row),
    .i_win_col   (sel_col),
    .o_win       (win),
    .o_kernel    (kernel),
    .o_win_valid (win_valid)
  );

  // same window to every pe with one filter each
  for (genvar f = 0; f < cnn_pkg::n_filt; f++) begin : g_pe
    conv_pe u_pe (
      .clk         (clk),
      .rst         (rst),
      .i_win       (win),
      .i_kernel    (kernel[f]),
      .i_valid     (win_valid),
      .o_res       (res[f]),
      .o_res_valid (res_valid[f])
    );
  end

  max_pool u_pool (
    .clk         (clk),
    .rst         (rst),
    .i_res       (res),
    .i_res_valid (res_valid),
    .o_temp_req  (o_temp_req),
    .o_pool_last (pool_last)
  );

endmodule

// ==== src/max_pool.sv ====
module max_pool (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [cnn_pkg::px_w-1:0]    i_res [cnn_pkg::n_filt],
  input  logic [cnn_pkg::n_filt-1:0]  i_res_valid,
  output cnn_pkg::bram_req_t          o_temp_req,
  output logic                        o_pool_last
);

  logic [cnn_pkg::px_w-1:0] shift_q [cnn_pkg::n_filt][4]; // last four results
  logic [cnn_pkg::px_w-1:0] pool_max [cnn_pkg::n_filt];
  logic                     res_valid;
  logic [2:0]               res_cnt;  // group in bit 2
  logic                     pool_go;  // shift holds a full group
  logic                     pool_grp;
  logic                     second_q; // upper word due
  cnn_pkg::bram_word_u      word_lo;
  cnn_pkg::bram_word_u      word_hi;
  cnn_pkg::bram_word_u      hold_hi;

  assign res_valid = &i_res_valid; // pes run in lockstep

  always_ff @(posedge clk) begin
    if (res_valid) begin
      for (int f = 0; f < cnn_pkg::n_filt; f++) begin
        shift_q[f][0] <= i_res[f];
        for (int k = 1; k < 4; k++) begin
          shift_q[f][k] <= shift_q[f][k-1];
        end
      end
    end
  end

  // unsigned max of four and then pack filters 4h..4h+3 into word h
  always_comb begin
    for (int f = 0; f < cnn_pkg::n_filt; f++) begin
      pool_max[f] = shift_q[f][0];
      for (int k = 1; k < 4; k++) begin
        if (shift_q[f][k] > pool_max[f]) pool_max[f] = shift_q[f][k];
      end
    end
    for (int b = 0; b < cnn_pkg::word_bytes; b++) begin
      word_lo.bytes[b] = pool_max[b];
      word_hi.bytes[b] = pool_max[cnn_pkg::word_bytes + b];
    end
  end

  always_ff @(posedge clk) begin
    if (pool_go) hold_hi <= word_hi; // next group may shift in meanwhile
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      res_cnt     <= '0;
      pool_go     <= 1'b0;
      pool_grp    <= 1'b0;
      second_q    <= 1'b0;
      o_pool_last <= 1'b0;
      o_temp_req  <= '0;
    end else begin
      if (res_valid) res_cnt <= res_cnt + 3'd1;
      pool_go <= res_valid && (res_cnt[1:0] == 2'd3);
      if (res_valid && res_cnt[1:0] == 2'd3) pool_grp <= res_cnt[2];
      second_q    <= pool_go;
      o_pool_last <= second_q && pool_grp;
      if (pool_go) begin
        o_temp_req.addr <= cnn_pkg::addr_w'({pool_grp, 1'b0});
        o_temp_req.en   <= 1'b1;
        o_temp_req.we   <= 4'b1111;
        o_temp_req.din  <= word_lo.word;
      end else if (second_q) begin
        o_temp_req.addr <= cnn_pkg::addr_w'({pool_grp, 1'b1});
        o_temp_req.en   <= 1'b1;
        o_temp_req.we   <= 4'b1111;
        o_temp_req.din  <= hold_hi.word;
      end else begin
        o_temp_req.en <= 1'b0;
        o_temp_req.we <= 4'b0000;
      end
    end
  end

endmodule

// ==== src/conv_pe.sv ====
module conv_pe (
  input  logic                     clk,
  input  logic                     rst,
  input  cnn_pkg::window_t         i_win,
  input  cnn_pkg::window_t         i_kernel,
  input  logic                     i_valid,
  output logic [cnn_pkg::px_w-1:0] o_res,
  output logic                     o_res_valid
);

  logic signed [2*cnn_pkg::px_w-1:0] prod_q [cnn_pkg::k_taps];
  logic                              prod_valid_q;
  logic signed [cnn_pkg::acc_w-1:0]  sum_d;
  logic signed [cnn_pkg::acc_w-1:0]  sum_q;
  logic [cnn_pkg::acc_w-1:0]         relu;

  // stage 1 forms 25 signed 8x8 products
  always_ff @(posedge clk) begin
    for (int t = 0; t < cnn_pkg::k_taps; t++) begin
      prod_q[t] <= $signed(i_win[t]) * $signed(i_kernel[t]);
    end
  end

  // stage 2 adder tree
  always_comb begin
    sum_d = '0;
    for (int t = 0; t < cnn_pkg::k_taps; t++) begin
      sum_d = sum_d + cnn_pkg::acc_w'(prod_q[t]); // sign extended
    end
  end

  always_ff @(posedge clk) begin
    sum_q <= sum_d;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      prod_valid_q <= 1'b0;
      o_res_valid  <= 1'b0;
    end else begin
      prod_valid_q <= i_valid;
      o_res_valid  <= prod_valid_q;
    end
  end

  assign relu = sum_q[cnn_pkg::acc_w-1] ? '0 : sum_q;

  // bits 14:7 rounded with bit 6 and wrapped at 8 bits
  assign o_res = relu[cnn_pkg::q_lsb +: cnn_pkg::px_w] +
                 cnn_pkg::px_w'(relu[cnn_pkg::q_lsb-1]);

endmodule

// ==== src/tile_cache.sv ====
module tile_cache (
  input  logic                clk,
  input  logic                rst,
  input  cnn_pkg::bram_word_u i_if_dout,
  input  cnn_pkg::bram_word_u i_w_dout,
  input  logic                i_load_if,
  input  logic                i_load_w,
  input  logic [5:0]          i_load_idx,
  input  logic                i_win_valid,
  input  logic                i_win_row,
  input  logic [1:0]          i_win_col,
  output cnn_pkg::window_t    o_win,
  output cnn_pkg::window_t    o_kernel [cnn_pkg::n_filt],
  output logic                o_win_valid
);

  // 6x8 tile in row major order
  logic [cnn_pkg::px_w-1:0] tile_mem [cnn_pkg::tile_rows * cnn_pkg::tile_cols];
  // filter f at 25f..25f+24
  logic [cnn_pkg::px_w-1:0] w_mem [cnn_pkg::n_filt * cnn_pkg::k_taps];

  // one word is four consecutive entries with byte 0 first
  always_ff @(posedge clk) begin
    if (i_load_if) begin
      for (int b = 0; b < cnn_pkg::word_bytes; b++) begin
        tile_mem[cnn_pkg::word_bytes * i_load_idx + b] <= i_if_dout.bytes[b];
      end
    end
    if (i_load_w) begin
      for (int b = 0; b < cnn_pkg::word_bytes; b++) begin
        w_mem[cnn_pkg::word_bytes * i_load_idx + b] <= i_w_dout.bytes[b];
      end
    end
  end

  // registered window select
  always_ff @(posedge clk) begin
    if (i_win_valid) begin
      for (int i = 0; i < cnn_pkg::k_size; i++) begin
        for (int j = 0; j < cnn_pkg::k_size; j++) begin
          o_win[i * cnn_pkg::k_size + j] <=
            tile_mem[cnn_pkg::tile_cols * (i_win_row + i) + i_win_col + j];
        end
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_win_valid <= 1'b0;
    end else begin
      o_win_valid <= i_win_valid;
    end
  end

  // kernels stay put for the whole run
  always_comb begin
    for (int f = 0; f < cnn_pkg::n_filt; f++) begin
      for (int t = 0; t < cnn_pkg::k_taps; t++) begin
        o_kernel[f][t] = w_mem[f * cnn_pkg::k_taps + t];
      end
    end
  end

endmodule

// ==== src/cnn_ctrl.sv ====
module cnn_ctrl (
  input  logic               clk,
  input  logic               rst,
  input  logic               i_start,
  input  logic               i_pool_last,
  output cnn_pkg::bram_req_t o_if_req,
  output cnn_pkg::bram_req_t o_w_req,
  output logic               o_load_if,
  output logic               o_load_w,
  output logic [5:0]         o_load_idx,
  output logic               o_win_valid,
  output logic               o_win_row,
  output logic [1:0]         o_win_col,
  output logic               o_done
);

  typedef enum logic [2:0] {
    st_idle,
    st_load,   // weight and tile reads plus one drain cycle
    st_run,    // one window per cycle
    st_wait,   // pipeline and pooling flush
    st_done
  } state_t;

  state_t     state;
  state_t     state_nx;
  logic [5:0] cnt;        // shared by load and run
  logic       cnt_end;
  logic       w_rd;
  logic       if_rd;

  assign cnt_end = (state == st_load && cnt == 6'(cnn_pkg::w_words)) ||
                   (state == st_run && cnt == 6'(cnn_pkg::n_win - 1));

  always_comb begin
    state_nx = state;
    case (state)
      st_idle: if (i_start) state_nx = st_load;
      st_load: if (cnt_end) state_nx = st_run;
      st_run:  if (cnt_end) state_nx = st_wait;
      st_wait: if (i_pool_last) state_nx = st_done;
      st_done: state_nx = st_idle;
      default: state_nx = st_idle;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      state <= state_nx;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt <= '0;
    end else if (cnt_end || state == st_idle) begin
      cnt <= '0;
    end else if (state == st_load || state == st_run) begin
      cnt <= cnt + 6'd1;
    end
  end

  // tile words come in on the first 12 weight cycles
  assign w_rd  = (state == st_load) && (cnt < 6'(cnn_pkg::w_words));
  assign if_rd = (state == st_load) && (cnt < 6'(cnn_pkg::if_words));

  always_comb begin
    o_w_req      = '0;
    o_w_req.addr = cnn_pkg::addr_w'(cnt);
    o_w_req.en   = w_rd;
    o_if_req      = '0;
    o_if_req.addr = cnn_pkg::addr_w'(cnt);
    o_if_req.en   = if_rd;
  end

  // data shows up one cycle after the read so the strobes trail by one
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_load_w   <= 1'b0;
      o_load_if  <= 1'b0;
      o_load_idx <= '0;
    end else begin
      o_load_w   <= w_rd;
      o_load_if  <= if_rd;
      o_load_idx <= cnt;
    end
  end

  // order 1 2 5 6 then 3 4 7 8
  // row from bit 1 and column from bits 2 and 0
  assign o_win_valid = (state == st_run);
  assign o_win_row   = cnt[1];
  assign o_win_col   = {cnt[2], cnt[0]};

  assign o_done = (state == st_done);

endmodule

// ==== src/cnn_pkg.sv ====
package cnn_pkg;

  // bram interface
  localparam int data_w = 32;
  localparam int addr_w = 32;

  // pixel and weight width
  localparam int px_w = 8;
  localparam int word_bytes = data_w / px_w; // bytes per bram word

  // kernel geometry
  localparam int k_size = 5;
  localparam int k_taps = k_size * k_size;
  localparam int n_filt = 8;                 // one pe per filter

  // input tile of 6 rows by 8 pixels
  localparam int tile_rows = 6;
  localparam int tile_cols = 8;

  // word counts for the three brams
  localparam int w_words   = 50;             // 8 x 25 weights at four per word
  localparam int if_words  = 12;             // 48 tile pixels
  localparam int n_win     = 8;
  localparam int out_words = 4;

  // accumulator and quantisation
  localparam int acc_w = 32;
  localparam int q_lsb = 7;                  // rounding bit is q_lsb-1

  // one command on a bram port
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic              en;
    logic [3:0]        we;                   // 1111 for write and 0000 for read
    logic [data_w-1:0] din;
  } bram_req_t;

  // byte 0 sits in bits 31:24
  typedef union packed {
    logic [data_w-1:0]                word;
    logic [0:word_bytes-1][px_w-1:0]  bytes;
  } bram_word_u;

  // 5x5 window or kernel with tap i*5+j at row i col j
  typedef logic [k_taps-1:0][px_w-1:0] window_t;

endpackage
